/* periph_pkg.sv */
// Shared bus, register map and struct types; full-word accesses only, NUM_SRC up to 32
package periph_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;
    localparam int ID_W   = 8;
    localparam int PRIO_W = 3;

    typedef logic [PRIO_W-1:0] prio_t;
    typedef logic [ID_W-1:0]   src_id_t;

    // ----------------------------------------
    // Register map, byte offsets
    // ----------------------------------------
    // Priority words start at 0x000, word n belongs to source n
    localparam logic [ADDR_W-1:0] PRIO_OFF     = 12'h000;
    localparam logic [ADDR_W-1:0] PEND_OFF     = 12'h100;
    localparam logic [ADDR_W-1:0] ENA_OFF      = 12'h104;
    localparam logic [ADDR_W-1:0] THR_OFF      = 12'h108;
    localparam logic [ADDR_W-1:0] CLAIM_OFF    = 12'h10C;
    localparam logic [ADDR_W-1:0] TMR_CTRL_OFF = 12'h200;
    localparam logic [ADDR_W-1:0] TMR_CNT_OFF  = 12'h204;
    localparam logic [ADDR_W-1:0] TMR_CMP_OFF  = 12'h208;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef enum logic [1:0] {
        TGT_PLIC,
        TGT_TIMER,
        TGT_NONE
    } target_e;

    typedef enum logic [1:0] {
        AXIL_IDLE,
        AXIL_WRESP,
        AXIL_RRESP
    } axil_state_e;

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0]   aw_addr;
        logic                aw_valid;
        logic [DATA_W-1:0]   w_data;
        logic [DATA_W/8-1:0] w_strb;
        logic                w_valid;
        logic                b_ready;
        logic [ADDR_W-1:0]   ar_addr;
        logic                ar_valid;
        logic                r_ready;
    } axil_req_t;

    typedef struct packed {
        logic              aw_ready;
        logic              w_ready;
        logic              ar_ready;
        logic              b_valid;
        logic [1:0]        b_resp;
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
        logic [1:0]        r_resp;
    } axil_rsp_t;

    // Offset is a word index, the two low address bits are dropped
    typedef struct packed {
        logic              valid;
        logic              write;
        target_e           target;
        logic [ADDR_W-3:0] offset;
        logic [DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              err;
    } reg_rsp_t;

    typedef struct packed {
        logic    claim;
        logic    complete;
        src_id_t id;
    } irq_ack_t;

endpackage

/* axil_slave_port.sv */
// One transaction at a time; AW and W must arrive together, strobes are ignored
`timescale 1ns/1ps

module axil_slave_port
    import periph_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  axil_req_t axil_req_i,
    output axil_rsp_t axil_rsp_o,
    output reg_req_t  reg_req_o,
    input  reg_rsp_t  tmr_rsp_i,
    input  reg_rsp_t  plic_rsp_i
);

    axil_state_e       state_q;
    logic [DATA_W-1:0] rdata_q;
    logic [1:0]        resp_q;
    logic              wr_acc;
    logic              rd_acc;
    logic [ADDR_W-1:0] acc_addr;
    target_e           tgt;
    reg_rsp_t          sel_rsp;

    // ----------------------------------------
    // Accept and decode
    // ----------------------------------------
    // Write wins over a read offered in the same cycle
    assign wr_acc   = (state_q == AXIL_IDLE) && axil_req_i.aw_valid && axil_req_i.w_valid;
    assign rd_acc   = (state_q == AXIL_IDLE) && axil_req_i.ar_valid && !wr_acc;
    assign acc_addr = wr_acc ? axil_req_i.aw_addr : axil_req_i.ar_addr;

    // PLIC owns 0x000-0x1FF, timer 0x200-0x2FF
    always_comb begin
        case (acc_addr[ADDR_W-1:8])
            4'h0, 4'h1: tgt = TGT_PLIC;
            4'h2:       tgt = TGT_TIMER;
            default:    tgt = TGT_NONE;
        endcase
    end

    assign reg_req_o.valid  = wr_acc || rd_acc;
    assign reg_req_o.write  = wr_acc;
    assign reg_req_o.target = tgt;
    assign reg_req_o.offset = acc_addr[ADDR_W-1:2];
    assign reg_req_o.wdata  = axil_req_i.w_data;

    // Response select, unmapped gives error with zero data
    always_comb begin
        case (tgt)
            TGT_PLIC:  sel_rsp = plic_rsp_i;
            TGT_TIMER: sel_rsp = tmr_rsp_i;
            default: begin
                sel_rsp.rdata = '0;
                sel_rsp.err   = 1'b1;
            end
        endcase
    end

    // ----------------------------------------
    // Response FSM
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= AXIL_IDLE;
            rdata_q <= '0;
            resp_q  <= RESP_OKAY;
        end else begin
            case (state_q)
                AXIL_IDLE: begin
                    if (wr_acc) begin
                        state_q <= AXIL_WRESP;
                        resp_q  <= sel_rsp.err ? RESP_SLVERR : RESP_OKAY;
                    end else if (rd_acc) begin
                        state_q <= AXIL_RRESP;
                        rdata_q <= sel_rsp.rdata;
                        resp_q  <= sel_rsp.err ? RESP_SLVERR : RESP_OKAY;
                    end
                end
                AXIL_WRESP: begin
                    if (axil_req_i.b_ready) begin
                        state_q <= AXIL_IDLE;
                    end
                end
                AXIL_RRESP: begin
                    if (axil_req_i.r_ready) begin
                        state_q <= AXIL_IDLE;
                    end
                end
                default: state_q <= AXIL_IDLE;
            endcase
        end
    end

    // Readies only in idle, so nothing is taken while a response waits
    assign axil_rsp_o.aw_ready = wr_acc;
    assign axil_rsp_o.w_ready  = wr_acc;
    assign axil_rsp_o.ar_ready = rd_acc;
    assign axil_rsp_o.b_valid  = (state_q == AXIL_WRESP);
    assign axil_rsp_o.b_resp   = resp_q;
    assign axil_rsp_o.r_valid  = (state_q == AXIL_RRESP);
    assign axil_rsp_o.r_data   = rdata_q;
    assign axil_rsp_o.r_resp   = resp_q;

endmodule

/* periph_timer.sv */
// 32-bit up counter with compare; level interrupt, count wraps silently at 2^32
`timescale 1ns/1ps

module periph_timer
    import periph_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  reg_req_t reg_req_i,
    output reg_rsp_t reg_rsp_o,
    output logic     tmr_irq_o
);

    logic              en_q;
    logic              en_d;
    logic [DATA_W-1:0] cnt_q;
    logic [DATA_W-1:0] cnt_d;
    logic [DATA_W-1:0] cmp_q;
    logic [DATA_W-1:0] cmp_d;
    logic              tmr_irq_q;
    logic              wr;
    logic [ADDR_W-1:0] boff;

    assign wr   = reg_req_i.valid && reg_req_i.write && (reg_req_i.target == TGT_TIMER);
    assign boff = {reg_req_i.offset, 2'b00};

    // Next state, a software write overrides the count step
    always_comb begin
        en_d  = en_q;
        cmp_d = cmp_q;
        cnt_d = en_q ? cnt_q + 1'b1 : cnt_q;
        if (wr) begin
            case (boff)
                TMR_CTRL_OFF: en_d  = reg_req_i.wdata[0];
                TMR_CNT_OFF:  cnt_d = reg_req_i.wdata;
                TMR_CMP_OFF:  cmp_d = reg_req_i.wdata;
                default: ;
            endcase
        end
    end

    // Level follows the new register values
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            en_q      <= 1'b0;
            cnt_q     <= '0;
            cmp_q     <= '0;
            tmr_irq_q <= 1'b0;
        end else begin
            en_q      <= en_d;
            cnt_q     <= cnt_d;
            cmp_q     <= cmp_d;
            tmr_irq_q <= en_d && (cnt_d >= cmp_d);
        end
    end

    always_comb begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.err   = 1'b0;
        case (boff)
            TMR_CTRL_OFF: reg_rsp_o.rdata = {{(DATA_W-1){1'b0}}, en_q};
            TMR_CNT_OFF:  reg_rsp_o.rdata = cnt_q;
            TMR_CMP_OFF:  reg_rsp_o.rdata = cmp_q;
            default:      reg_rsp_o.err   = 1'b1;
        endcase
    end

    assign tmr_irq_o = tmr_irq_q;

endmodule

/* irq_gateway.sv */
// Level-sensitive sources only; a held source re-pends only after its complete
`timescale 1ns/1ps

module irq_gateway
    import periph_pkg::*;
#(
    parameter int NUM_SRC = 8
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [NUM_SRC-1:0] src_i,
    input  irq_ack_t           ack_i,
    output logic [NUM_SRC-1:0] pending_o
);

    logic [NUM_SRC-1:0] pend_q;
    logic [NUM_SRC-1:0] infl_q;
    logic [NUM_SRC-1:0] claim_hit;
    logic [NUM_SRC-1:0] done_hit;

    // One-hot decode of the acknowledged id
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            claim_hit[i] = ack_i.claim && (ack_i.id == src_id_t'(i));
            done_hit[i]  = ack_i.complete && (ack_i.id == src_id_t'(i));
        end
    end

    // ----------------------------------------
    // Pending and in-flight state
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pend_q <= '0;
            infl_q <= '0;
        end else begin
            // Claim beats a new level in the same cycle
            pend_q <= (pend_q | (src_i & ~infl_q)) & ~claim_hit;
            infl_q <= (infl_q | claim_hit) & ~done_hit;
        end
    end

    assign pending_o = pend_q;

endmodule

/* irq_arbiter.sv */
// Single target; ties go to the lowest id and priority 0 never wins
`timescale 1ns/1ps

module irq_arbiter
    import periph_pkg::*;
#(
    parameter int NUM_SRC = 8
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic [NUM_SRC-1:0]  pending_i,
    input  logic [NUM_SRC-1:0]  enable_i,
    input  prio_t [NUM_SRC-1:0] prio_i,
    input  prio_t               threshold_i,
    output src_id_t             best_id_o,
    output logic                irq_o
);

    src_id_t best_id_d;
    prio_t   best_prio;
    src_id_t best_id_q;
    logic    irq_q;

    // Linear scan, strict compare keeps the lower id on a tie
    always_comb begin
        best_id_d = '0;
        best_prio = '0;
        for (int i = 1; i < NUM_SRC; i++) begin
            if (pending_i[i] && enable_i[i] && (prio_i[i] > best_prio)) begin
                best_id_d = src_id_t'(i);
                best_prio = prio_i[i];
            end
        end
    end

    // ----------------------------------------
    // Output stage
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            best_id_q <= '0;
            irq_q     <= 1'b0;
        end else begin
            best_id_q <= best_id_d;
            // No candidate leaves best_prio at 0, which never exceeds a threshold
            irq_q     <= (best_prio > threshold_i);
        end
    end

    assign best_id_o = best_id_q;
    assign irq_o     = irq_q;

endmodule

/* plic_regs.sv */
// Priority word 0 is fixed at 0; pending is read-only and writes to it are dropped
`timescale 1ns/1ps

module plic_regs
    import periph_pkg::*;
#(
    parameter int NUM_SRC = 8
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  reg_req_t            reg_req_i,
    output reg_rsp_t            reg_rsp_o,
    input  logic [NUM_SRC-1:0]  pending_i,
    input  src_id_t             best_id_i,
    output prio_t [NUM_SRC-1:0] prio_o,
    output logic [NUM_SRC-1:0]  enable_o,
    output prio_t               threshold_o,
    output irq_ack_t            ack_o
);

    prio_t [NUM_SRC-1:0] prio_q;
    logic [NUM_SRC-1:0]  ena_q;
    prio_t               thr_q;
    logic                hit;
    logic                wr;
    logic [ADDR_W-1:0]   boff;
    logic [NUM_SRC-1:0]  prio_sel;
    logic                claim_sel;

    assign hit       = reg_req_i.valid && (reg_req_i.target == TGT_PLIC);
    assign wr        = hit && reg_req_i.write;
    assign boff      = {reg_req_i.offset, 2'b00};
    assign claim_sel = (boff == CLAIM_OFF);

    // Word index selects one priority register
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            prio_sel[i] = (boff - PRIO_OFF) == ADDR_W'(4 * i);
        end
    end

    // ----------------------------------------
    // Register writes
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prio_q <= '0;
            ena_q  <= '0;
            thr_q  <= '0;
        end else if (wr) begin
            for (int i = 1; i < NUM_SRC; i++) begin
                if (prio_sel[i]) begin
                    prio_q[i] <= reg_req_i.wdata[PRIO_W-1:0];
                end
            end
            if (boff == ENA_OFF) begin
                ena_q <= reg_req_i.wdata[NUM_SRC-1:0];
            end
            if (boff == THR_OFF) begin
                thr_q <= reg_req_i.wdata[PRIO_W-1:0];
            end
        end
    end

    // ----------------------------------------
    // Read mux
    // ----------------------------------------
    always_comb begin
        reg_rsp_o.rdata = '0;
        reg_rsp_o.err   = 1'b0;
        if (|prio_sel) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (prio_sel[i]) begin
                    reg_rsp_o.rdata = DATA_W'(prio_q[i]);
                end
            end
        end else begin
            case (boff)
                PEND_OFF:  reg_rsp_o.rdata = DATA_W'(pending_i);
                ENA_OFF:   reg_rsp_o.rdata = DATA_W'(ena_q);
                THR_OFF:   reg_rsp_o.rdata = DATA_W'(thr_q);
                CLAIM_OFF: reg_rsp_o.rdata = DATA_W'(best_id_i);
                default:   reg_rsp_o.err   = 1'b1;
            endcase
        end
    end

    // Claim on read of a real id, complete on any write
    assign ack_o.claim    = hit && !reg_req_i.write && claim_sel && (best_id_i != '0);
    assign ack_o.complete = wr && claim_sel;
    assign ack_o.id       = reg_req_i.write ? reg_req_i.wdata[ID_W-1:0] : best_id_i;

    assign prio_o      = prio_q;
    assign enable_o    = ena_q;
    assign threshold_o = thr_q;

endmodule

/* periph_top.sv */
// Source 0 unused, source 1 is the timer, irq_src_i feeds sources 2 and up; NUM_SRC 3 to 32
`timescale 1ns/1ps

module periph_top
    import periph_pkg::*;
#(
    parameter int NUM_SRC = 8
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  axil_req_t          axil_req_i,
    output axil_rsp_t          axil_rsp_o,
    input  logic [NUM_SRC-3:0] irq_src_i,
    output logic               irq_o
);

    reg_req_t            reg_req;
    reg_rsp_t            tmr_rsp;
    reg_rsp_t            plic_rsp;
    logic                tmr_irq;
    logic [NUM_SRC-1:0]  src_lvl;
    logic [NUM_SRC-1:0]  pending;
    logic [NUM_SRC-1:0]  enable;
    prio_t [NUM_SRC-1:0] prio;
    prio_t               threshold;
    src_id_t             best_id;
    irq_ack_t            ack;

    // Source map
    assign src_lvl = {irq_src_i, tmr_irq, 1'b0};

    // ----------------------------------------
    // Bus side
    // ----------------------------------------
    axil_slave_port i_axil_slave_port (
        .clk_i      ( clk_i      ),
        .rst_n_i    ( rst_n_i    ),
        .axil_req_i ( axil_req_i ),
        .axil_rsp_o ( axil_rsp_o ),
        .reg_req_o  ( reg_req    ),
        .tmr_rsp_i  ( tmr_rsp    ),
        .plic_rsp_i ( plic_rsp   )
    );

    periph_timer i_timer (
        .clk_i     ( clk_i   ),
        .rst_n_i   ( rst_n_i ),
        .reg_req_i ( reg_req ),
        .reg_rsp_o ( tmr_rsp ),
        .tmr_irq_o ( tmr_irq )
    );

    plic_regs #(
        .NUM_SRC ( NUM_SRC )
    ) i_plic_regs (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .reg_req_i   ( reg_req   ),
        .reg_rsp_o   ( plic_rsp  ),
        .pending_i   ( pending   ),
        .best_id_i   ( best_id   ),
        .prio_o      ( prio      ),
        .enable_o    ( enable    ),
        .threshold_o ( threshold ),
        .ack_o       ( ack       )
    );

    // ----------------------------------------
    // Interrupt pipeline
    // ----------------------------------------
    irq_gateway #(
        .NUM_SRC ( NUM_SRC )
    ) i_irq_gateway (
        .clk_i     ( clk_i   ),
        .rst_n_i   ( rst_n_i ),
        .src_i     ( src_lvl ),
        .ack_i     ( ack     ),
        .pending_o ( pending )
    );

    irq_arbiter #(
        .NUM_SRC ( NUM_SRC )
    ) i_irq_arbiter (
        .clk_i       ( clk_i     ),
        .rst_n_i     ( rst_n_i   ),
        .pending_i   ( pending   ),
        .enable_i    ( enable    ),
        .prio_i      ( prio      ),
        .threshold_i ( threshold ),
        .best_id_o   ( best_id   ),
        .irq_o       ( irq_o     )
    );

endmodule

/* tb_clk_gen.sv */
// Free-running clock from time 0; reset is held low for the first two rising edges
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD = 10
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial clk_o = 1'b0;
    always #(PERIOD / 2) clk_o = ~clk_o;

    // Release on a falling edge, away from the DUT sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* periph_chk.sv */
// Bound to axil_slave_port; protocol checks are off during reset, the reset check is not
`timescale 1ns/1ps

module periph_chk
    import periph_pkg::*;
(
    input logic      clk_i,
    input logic      rst_n_i,
    input axil_req_t axil_req_i,
    input axil_rsp_t axil_rsp_i
);

    // Write response held until taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axil_rsp_i.b_valid && !axil_req_i.b_ready |=> axil_rsp_i.b_valid)
        else $error("b valid dropped before b ready");

    // Read response held, data unchanged
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        axil_rsp_i.r_valid && !axil_req_i.r_ready |=>
            axil_rsp_i.r_valid && $stable(axil_rsp_i.r_data))
        else $error("r valid or r data changed before r ready");

    // Nothing accepted while a response waits
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (axil_rsp_i.b_valid || axil_rsp_i.r_valid) |->
            !axil_rsp_i.aw_ready && !axil_rsp_i.w_ready && !axil_rsp_i.ar_ready)
        else $error("ready high while a response is pending");

    // Readies and valids low once a reset edge has been seen
    assert property (@(posedge clk_i)
        !rst_n_i |=> !axil_rsp_i.b_valid && !axil_rsp_i.r_valid &&
            !axil_rsp_i.aw_ready && !axil_rsp_i.w_ready && !axil_rsp_i.ar_ready)
        else $error("port outputs not low after reset");

endmodule

bind axil_slave_port periph_chk periph_chk_inst (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .axil_req_i ( axil_req_i ),
    .axil_rsp_i ( axil_rsp_o )
);

/* periph_tb.sv */
// Runs with NUM_SRC 8 only; the timer is assumed off outside the timer test
`timescale 1ns/1ps

module periph_tb
    import periph_pkg::*;
;

    localparam int NUM_SRC = 8;
    localparam int NUM_TXN = 300;

    logic               clk;
    logic               rst_n;
    axil_req_t          req;
    axil_rsp_t          rsp;
    logic [NUM_SRC-3:0] src_lvl;
    logic               irq;

    // Reference model state
    logic [PRIO_W-1:0]  m_prio [NUM_SRC];
    logic [NUM_SRC-1:0] m_ena;
    logic [PRIO_W-1:0]  m_thr;
    logic [NUM_SRC-1:0] m_pend;
    logic [NUM_SRC-1:0] m_infl;

    string       name_q [$];
    logic [31:0] exp_q  [$];
    logic [31:0] act_q  [$];
    int          err_cnt;
    int          chk_cnt;
    int          test_cnt;
    int          seed;

    tb_clk_gen #(.PERIOD(10)) clk_gen_inst (
        .clk_o   ( clk   ),
        .rst_n_o ( rst_n )
    );

    periph_top #(
        .NUM_SRC ( NUM_SRC )
    ) periph_top_inst (
        .clk_i      ( clk     ),
        .rst_n_i    ( rst_n   ),
        .axil_req_i ( req     ),
        .axil_rsp_o ( rsp     ),
        .irq_src_i  ( src_lvl ),
        .irq_o      ( irq     )
    );

    // ----------------------------------------
    // Reference model and compare
    // ----------------------------------------
    // Highest priority level first, lowest id within that level
    function automatic logic [ID_W-1:0] ref_best_id();
        logic [ID_W-1:0] best;
        logic            found;
        best  = '0;
        found = 1'b0;
        for (int p = (1 << PRIO_W) - 1; p > 0; p--) begin
            for (int i = 1; i < NUM_SRC; i++) begin
                if (!found && m_pend[i] && m_ena[i] && (int'(m_prio[i]) == p)) begin
                    best  = ID_W'(i);
                    found = 1'b1;
                end
            end
        end
        return best;
    endfunction

    function automatic logic ref_irq();
        logic [ID_W-1:0] best;
        best = ref_best_id();
        return (best != 0) && (m_prio[best] > m_thr);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    always @(posedge clk) begin
        string       nm;
        logic [31:0] e;
        logic [31:0] a;
        while (act_q.size() > 0) begin
            nm = name_q.pop_front();
            e  = exp_q.pop_front();
            a  = act_q.pop_front();
            chk_cnt++;
            assert (e === a) else begin
                err_cnt++;
                $display("mismatch %s expected 0x%0h actual 0x%0h", nm, e, a);
            end
        end
    end

    task automatic report_fail(input string msg);
        err_cnt++;
        $display("error: %s", msg);
    endtask

    task automatic end_test(input string name, input int e0);
        repeat (2) @(posedge clk);
        test_cnt++;
        $display("test %s: %s", name, (err_cnt == e0) ? "ok" : "failed");
    endtask

    // Model pending follows the levels of sources not in flight
    task automatic settle(input int n);
        repeat (n) @(negedge clk);
        m_pend = m_pend | ({src_lvl, 2'b00} & ~m_infl);
    endtask

    // ----------------------------------------
    // AXI4-Lite access
    // ----------------------------------------
    task automatic axil_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        @(negedge clk);
        req.aw_addr  = addr;
        req.aw_valid = 1'b1;
        req.w_data   = data;
        req.w_strb   = '1;
        req.w_valid  = 1'b1;
        req.b_ready  = 1'b1;
        #1;
        n = 0;
        while (!(rsp.aw_ready && rsp.w_ready) && n < 20) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (n >= 20) report_fail("write address or data never accepted");
        @(negedge clk);
        req.aw_valid = 1'b0;
        req.w_valid  = 1'b0;
        n = 0;
        while (!rsp.b_valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n >= 20) report_fail("no write response");
        resp = rsp.b_resp;
        @(negedge clk);
        req.b_ready = 1'b0;
    endtask

    // Hold keeps r ready low for that many cycles once r valid is seen
    task automatic axil_read(input logic [ADDR_W-1:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        int          n;
        logic [31:0] first;
        @(negedge clk);
        req.ar_addr  = addr;
        req.ar_valid = 1'b1;
        req.r_ready  = (hold == 0);
        #1;
        n = 0;
        while (!rsp.ar_ready && n < 20) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (n >= 20) report_fail("read address never accepted");
        @(negedge clk);
        req.ar_valid = 1'b0;
        n = 0;
        while (!rsp.r_valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (n >= 20) report_fail("no read response");
        first = rsp.r_data;
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            check("bp_rvalid", 1, rsp.r_valid);
            check("bp_rdata", first, rsp.r_data);
        end
        req.r_ready = 1'b1;
        data = rsp.r_data;
        resp = rsp.r_resp;
        @(negedge clk);
        req.r_ready = 1'b0;
    endtask

    // ----------------------------------------
    // Register helpers that keep the model in step
    // ----------------------------------------
    task automatic set_prio(input int i, input logic [31:0] v);
        logic [1:0] r;
        axil_write(ADDR_W'(4 * i), v, r);
        m_prio[i] = v[PRIO_W-1:0];
    endtask

    task automatic set_ena(input logic [31:0] v);
        logic [1:0] r;
        axil_write(ENA_OFF, v, r);
        m_ena = v[NUM_SRC-1:0];
    endtask

    task automatic set_thr(input logic [31:0] v);
        logic [1:0] r;
        axil_write(THR_OFF, v, r);
        m_thr = v[PRIO_W-1:0];
    endtask

    task automatic claim_irq(output logic [ID_W-1:0] id);
        logic [31:0] d;
        logic [1:0]  r;
        axil_read(CLAIM_OFF, 0, d, r);
        id = d[ID_W-1:0];
        if (id != 0 && id < NUM_SRC) begin
            m_pend[id] = 1'b0;
            m_infl[id] = 1'b1;
        end
    endtask

    task automatic complete_irq(input logic [ID_W-1:0] id);
        logic [1:0] r;
        axil_write(CLAIM_OFF, 32'(id), r);
        if (id < NUM_SRC) m_infl[id] = 1'b0;
    endtask

    // Claims every pending source with all levels low
    task automatic drain();
        logic [ID_W-1:0] id;
        @(negedge clk);
        src_lvl = '0;
        for (int i = 1; i < NUM_SRC; i++) set_prio(i, 1);
        set_ena(32'hFE);
        set_thr(0);
        settle(3);
        for (int k = 0; k < NUM_SRC; k++) begin
            claim_irq(id);
            if (id == 0) break;
            complete_irq(id);
            settle(2);
        end
        m_pend = '0;
        m_infl = '0;
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic test_readback();
        logic [31:0] v;
        logic [31:0] d;
        logic [1:0]  r;
        int          e0;
        e0 = err_cnt;
        for (int i = 1; i < NUM_SRC; i++) begin
            v = $random(seed);
            set_prio(i, v);
            axil_read(ADDR_W'(4 * i), 0, d, r);
            check($sformatf("prio%0d", i), {29'b0, v[2:0]}, d);
        end
        axil_write(PRIO_OFF, 32'h7, r);
        axil_read(PRIO_OFF, 0, d, r);
        check("prio0", 0, d);
        v = $random(seed);
        set_ena(v);
        axil_read(ENA_OFF, 0, d, r);
        check("enable", v & 32'hFF, d);
        v = $random(seed);
        set_thr(v);
        axil_read(THR_OFF, 0, d, r);
        check("threshold", v & 32'h7, d);
        v = $random(seed);
        axil_write(TMR_CMP_OFF, v, r);
        axil_read(TMR_CMP_OFF, 0, d, r);
        check("tmr_cmp", v, d);
        axil_write(12'h300, 32'h1234, r);
        check("unmapped_wr_resp", RESP_SLVERR, r);
        axil_read(12'h300, 0, d, r);
        check("unmapped_rd_resp", RESP_SLVERR, r);
        check("unmapped_rd_data", 0, d);
        // Priority word of a source beyond NUM_SRC
        axil_read(12'h020, 0, d, r);
        check("prio_range_resp", RESP_SLVERR, r);
        end_test("readback", e0);
    endtask

    task automatic test_arbitration();
        logic [ID_W-1:0] id;
        logic [ID_W-1:0] exp_id;
        logic [31:0]     d;
        logic [1:0]      r;
        int              e0;
        e0 = err_cnt;
        drain();
        for (int i = 1; i < NUM_SRC; i++) set_prio(i, $random(seed));
        // Source 2 stays pending at priority 0 and must never win
        set_prio(2, 0);
        @(negedge clk);
        src_lvl = $random(seed);
        src_lvl[0] = 1'b1;
        settle(3);
        for (int k = 0; k < 4; k++) begin
            exp_id = ref_best_id();
            claim_irq(id);
            check("arb_claim", exp_id, id);
            if (id != 0) begin
                check("arb_prio_nonzero", 1, m_prio[id] != 0);
                axil_read(PEND_OFF, 0, d, r);
                check("arb_pend", m_pend, d);
                complete_irq(id);
                settle(2);
            end
        end
        end_test("arbitration", e0);
    endtask

    task automatic test_threshold();
        logic [31:0] v;
        int          e0;
        e0 = err_cnt;
        drain();
        for (int i = 1; i < NUM_SRC; i++) set_prio(i, $random(seed));
        @(negedge clk);
        src_lvl = $random(seed);
        settle(3);
        for (int k = 0; k < 8; k++) begin
            v = $random(seed);
            if (k % 2 == 1) set_thr(v);
            else set_ena(v);
            settle(2);
            check("thr_irq", ref_irq(), irq);
        end
        end_test("threshold", e0);
    endtask

    task automatic test_timer();
        logic [ID_W-1:0] id;
        logic [31:0]     d;
        logic [1:0]      r;
        int              n;
        int              e0;
        e0 = err_cnt;
        drain();
        set_ena(32'h02);
        set_thr(0);
        set_prio(1, 1);
        axil_write(TMR_CMP_OFF, 32'd6, r);
        axil_write(TMR_CNT_OFF, 32'd0, r);
        axil_write(TMR_CTRL_OFF, 32'd1, r);
        n = 0;
        while (!irq && n < 6 + 5) begin
            @(negedge clk);
            n++;
        end
        check("tmr_irq_rise", 1, irq);
        claim_irq(id);
        check("tmr_claim", 1, id);
        axil_write(TMR_CMP_OFF, 32'hFFFF_0000, r);
        complete_irq(1);
        settle(3);
        axil_read(PEND_OFF, 0, d, r);
        check("tmr_pend_clear", 0, d[1]);
        check("tmr_irq_low", 0, irq);
        axil_write(TMR_CTRL_OFF, 32'd0, r);
        end_test("timer", e0);
    endtask

    task automatic test_gateway();
        logic [ID_W-1:0] id;
        logic [31:0]     d;
        logic [1:0]      r;
        int              e0;
        e0 = err_cnt;
        drain();
        set_ena(32'h08);
        set_prio(3, 5);
        @(negedge clk);
        src_lvl[1] = 1'b1;
        settle(3);
        claim_irq(id);
        check("gw_claim", 3, id);
        axil_read(PEND_OFF, 0, d, r);
        check("gw_pend_claimed", 0, d[3]);
        settle(5);
        axil_read(PEND_OFF, 0, d, r);
        check("gw_pend_held", 0, d[3]);
        complete_irq(3);
        settle(2);
        axil_read(PEND_OFF, 0, d, r);
        check("gw_pend_again", 1, d[3]);
        end_test("gateway", e0);
    endtask

    task automatic test_backpressure();
        logic [31:0] d;
        logic [1:0]  r;
        int          e0;
        e0 = err_cnt;
        drain();
        set_prio(2, 6);
        axil_read(12'h008, 4, d, r);
        check("bp_data", 6, d);
        check("bp_resp", RESP_OKAY, r);
        end_test("backpressure", e0);
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------
    initial begin
        seed     = 32'h2398_c4ee;
        req      = '0;
        src_lvl  = '0;
        err_cnt  = 0;
        chk_cnt  = 0;
        test_cnt = 0;
        m_ena    = '0;
        m_thr    = '0;
        m_pend   = '0;
        m_infl   = '0;
        for (int i = 0; i < NUM_SRC; i++) m_prio[i] = '0;
        wait (rst_n);
        test_readback();
        test_arbitration();
        test_threshold();
        test_timer();
        test_gateway();
        test_backpressure();
        repeat (2) @(posedge clk);
        $display("tests %0d checks %0d errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        repeat (NUM_TXN * 50) @(posedge clk);
        $display("error: watchdog expired before the tests finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

/* vlog.f */
periph_pkg.sv
axil_slave_port.sv
periph_timer.sv
irq_gateway.sv
irq_arbiter.sv
plic_regs.sv
periph_top.sv
tb_clk_gen.sv
periph_chk.sv
periph_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module periph_tb -o periph_sim

./obj_dir/periph_sim | tee sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
